//--- logic/latch_mem_pkg.sv
`default_nettype none

// Shared sizes and types for the latch memory
package latch_mem_pkg;

  // Total number of stored bytes
  localparam int ram_bytes = 64;

  // Width of a full byte address
  localparam int addr_bits = 6;

  // The read path splits the array into banks of equal size
  localparam int bank_words = 16;
  localparam int num_banks = 4;

  // One stored byte, also the width of the write and read data pins
  typedef logic [7:0] data_t;

  // Byte address as it arrives on the low bits of the input pins
  typedef logic [addr_bits-1:0] addr_t;

  // Word index inside one bank, taken from the low address bits
  typedef logic [3:0] word_addr_t;

  // One bit per bank, exactly one of them set after a read edge
  typedef logic [num_banks-1:0] bank_sel_t;

  // A write captured on acceptance
  // Both fields stay constant until the next accepted request
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_req_t;

  // The whole array content as seen by the read path
  // Entry i holds the byte stored at address i
  typedef data_t [ram_bytes-1:0] mem_image_t;

endpackage

`default_nettype wire

//--- logic/write_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

// Turns a one-cycle write request into a half-cycle latch gate
//
// A request is taken at a rising edge and the address and data are held in
// wr_req from that edge on. The gate opens at the next rising edge, once the
// byte decode in the array has settled on the held address, and a flop on the
// falling edge closes it again in the middle of that cycle.
module write_sequencer import latch_mem_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    wr_strobe,
  input  addr_t   addr,
  input  data_t   wr_data,
  output wr_req_t wr_req,
  output logic    write_gate
);

  // Set for one cycle after the edge that accepted a request
  logic pending;

  // Set for one cycle after pending, this is the cycle the gate opens in
  logic valid;

  // Inverse of valid, sampled on the falling edge
  logic valid_n_fall;

  // A request that follows an accepted one is dropped
  logic accept;

  // Dropping the second request keeps wr_req from changing while the gate
  // of the first one is about to open
  assign accept = wr_strobe && !pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
      valid   <= 1'b0;
    end else begin
      pending <= accept;
      valid   <= pending;
    end
  end

  // Address and data are only loaded when a request is taken
  // They are therefore stable from one edge before the gate opens until
  // well after it has closed
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_req.addr <= addr;
      wr_req.data <= wr_data;
    end
  end

  // Still high when valid rises because two writes are never adjacent
  // Goes low half a cycle later and so ends the gate window
  always_ff @(negedge clk) begin
    valid_n_fall <= !valid;
  end

  // High for the first half of the cycle after acceptance
  assign write_gate = valid && valid_n_fall;

endmodule

`default_nettype wire

//--- logic/latch_array.sv
`timescale 1ns/100ps
`default_nettype none

// Storage made of 64 transparent byte latches
//
// Each byte has its own enable, formed from the address decode of the held
// write request and the common write gate. Since the address is already
// stable when the gate rises, only the addressed byte ever opens and the
// others keep their contents.
module latch_array import latch_mem_pkg::*; (
  input  wr_req_t    wr_req,
  input  logic       write_gate,
  output mem_image_t mem_image
);

  for (genvar i = 0; i < ram_bytes; i++) begin : g_byte

    // True when the held write targets this byte
    logic sel_byte;

    // Latch enable of this byte
    logic byte_en;

    // The stored byte itself
    data_t byte_q;

    assign sel_byte = (wr_req.addr == addr_t'(i));

    // The gate is the only signal here that toggles during a write cycle
    assign byte_en = write_gate && sel_byte;

    // Transparent while the enable is high
    // The value at the falling edge of the gate is kept
    always_latch begin
      if (byte_en) begin
        byte_q <= wr_req.data;
      end
    end

    assign mem_image[i] = byte_q;

  end

endmodule

`default_nettype wire

//--- logic/bank_read_mux.sv
`timescale 1ns/100ps
`default_nettype none

// Read path of the latch memory
//
// The array is split into four banks of sixteen words. The word index is
// registered once and shared by all banks, so every bank offers one byte.
// A registered one-hot select then passes exactly one of the four bytes.
// In a cell based build this merge would be a tri-state bus, here it is an
// AND-OR tree which gives the same result under a one-hot select.
module bank_read_mux import latch_mem_pkg::*; (
  input  logic       clk,
  input  addr_t      addr,
  input  mem_image_t mem_image,
  output data_t      rd_data
);

  // Number of address bits that pick a word inside a bank
  localparam int word_bits = $bits(word_addr_t);

  // Registered word index, shared by all four banks
  word_addr_t word_q;

  // Registered one-hot bank select
  bank_sel_t bank_sel_q;

  // Output of each bank multiplexer
  data_t bank_data [num_banks];

  // Both read registers sample on the same edge so the select and the
  // word index always describe the same address
  always_ff @(posedge clk) begin
    word_q     <= addr[word_bits-1:0];
    bank_sel_q <= bank_sel_t'(1) << addr[addr_bits-1:word_bits];
  end

  for (genvar b = 0; b < num_banks; b++) begin : g_bank

    // The sixteen words of this bank in address order
    data_t bank_word [bank_words];

    for (genvar w = 0; w < bank_words; w++) begin : g_word
      assign bank_word[w] = mem_image[b * bank_words + w];
    end

    // 16 to 1 multiplexer on the registered word index
    assign bank_data[b] = bank_word[word_q];

  end

  // Each bank is masked by its own select bit and the results are ORed
  // With a one-hot select this leaves the byte of the addressed bank
  always_comb begin
    rd_data = '0;
    for (int b = 0; b < num_banks; b++) begin
      rd_data = rd_data | (bank_data[b] & {$bits(data_t){bank_sel_q[b]}});
    end
  end

endmodule

`default_nettype wire

//--- logic/latch_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

// Top level of the latch memory
//
// ui_in   bits 5..0 carry the address for reads and writes
//         bit 7 requests a write, bit 6 is not used
// uio_in  carries the byte to be written
// uo_out  shows the byte at the address sampled at the last rising edge
//
// A write is accepted when bit 7 is high and no write was accepted at the
// edge before. The byte is stored in the first half of the next cycle and
// can be read back by a read sampled one edge after that.
module latch_mem_top import latch_mem_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] ui_in,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out
);

  // Address field shared by the write and read paths
  addr_t addr;

  // Write request from the top pin
  logic wr_strobe;

  // Byte to be written
  data_t wr_data;

  // Held write request and the latch gate
  wr_req_t wr_req;
  logic    write_gate;

  // Current contents of all bytes
  mem_image_t mem_image;

  // Byte selected by the read path
  data_t rd_data;

  assign addr      = ui_in[addr_bits-1:0];
  assign wr_strobe = ui_in[7];
  assign wr_data   = uio_in;
  assign uo_out    = rd_data;

  // Accepts requests and times the latch gate
  write_sequencer i_write_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_strobe  (wr_strobe),
    .addr       (addr),
    .wr_data    (wr_data),
    .wr_req     (wr_req),
    .write_gate (write_gate)
  );

  // The byte latches
  latch_array i_latch_array (
    .wr_req     (wr_req),
    .write_gate (write_gate),
    .mem_image  (mem_image)
  );

  // Banked read multiplexer with one edge of latency
  bank_read_mux i_bank_read_mux (
    .clk       (clk),
    .addr      (addr),
    .mem_image (mem_image),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

//--- test/tb_latch_mem.sv
`timescale 1ns/100ps
`default_nettype none

// Directed testbench for latch_mem_top
//
// All inputs change 0.5 ns after a rising edge and results are checked at the
// same point, when every register and latch has settled. A reference memory
// follows the write rules of the pin interface and decides what each read
// should return.
module tb_latch_mem import latch_mem_pkg::*; ();

  logic       clk;
  logic       rst_n;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;

  // Reference contents and a flag for each byte that has a known value
  data_t ref_mem   [ram_bytes];
  logic  ref_known [ram_bytes];

  // Write accepted at the last edge, committed at the next one unless reset
  logic  pend_valid;
  addr_t pend_addr;
  data_t pend_data;

  // LFSR state for random addresses and data
  logic [31:0] lfsr_state;

  // Number of rising edges so far, updated after the edge like any register
  int unsigned edge_count;

  latch_mem_top i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .ui_in  (ui_in),
    .uio_in (uio_in),
    .uo_out (uo_out)
  );

  // 4 ns clock period
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    edge_count <= edge_count + 1;
  end

  // Prints the reason and ends the run as failed
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Simulation stopped on an error");
  endtask

  task automatic check_data(input data_t got, input data_t expected, input string what);
    if (got !== expected) begin
      stop_run($sformatf("FAIL %0.1f ns: %s, got %02h expected %02h",
                         $realtime, what, got, expected));
    end
  endtask

  // One Galois step, polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // Collects n random bits, one LFSR step per bit
  task automatic take_bits(input int n, output logic [7:0] value);
    value = 8'h00;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[6:0], lfsr_state[0]};
    end
  endtask

  // Waits for the next rising edge by polling the edge counter
  // The counter changes after the edge, so the edge is always seen 0.1 ns late
  // and the final delay lands exactly 0.5 ns past it
  task automatic next_cycle();
    int unsigned start;
    int steps;
    start = edge_count;
    steps = 0;
    while (edge_count == start) begin
      #0.1;
      steps++;
      if (steps > 50) begin
        stop_run("Timed out waiting for a rising clock edge");
      end
    end
    #0.4;
  endtask

  // Reference model at one rising edge with the inputs that were driven
  // A write is taken when the strobe is high and none was taken at the edge
  // before, and it lands in the memory one edge later unless reset intervenes
  task automatic model_edge(input logic strobe, input addr_t addr, input data_t data);
    logic was_pending;
    was_pending = pend_valid;
    if (!rst_n) begin
      pend_valid = 1'b0;
    end else begin
      if (was_pending) begin
        ref_mem[pend_addr]   = pend_data;
        ref_known[pend_addr] = 1'b1;
      end
      pend_valid = strobe && !was_pending;
      if (pend_valid) begin
        pend_addr = addr;
        pend_data = data;
      end
    end
  endtask

  // Drives one cycle of pin values and advances past the sampling edge
  task automatic drive_cycle(input logic strobe, input addr_t addr, input data_t data);
    ui_in  = {strobe, 1'b0, addr};
    uio_in = data;
    next_cycle();
    model_edge(strobe, addr, data);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b0, '0, '0);
    end
    rst_n = 1'b1;
  endtask

  // Request cycle followed by one cycle with the strobe low
  task automatic do_write(input addr_t addr, input data_t data);
    drive_cycle(1'b1, addr, data);
    drive_cycle(1'b0, addr, '0);
  endtask

  // The address is sampled at the edge and uo_out shows the byte right after
  task automatic do_read(input addr_t addr, input string what);
    drive_cycle(1'b0, addr, '0);
    if (ref_known[addr]) begin
      check_data(data_t'(uo_out), ref_mem[addr], $sformatf("%s at address %0d", what, addr));
    end
  endtask

  // Random byte that differs from the one the model holds at addr
  task automatic fresh_data(input addr_t addr, output data_t data);
    logic [7:0] bits;
    take_bits(8, bits);
    data = bits;
    if (ref_known[addr] && data == ref_mem[addr]) begin
      data = ~data;
    end
  endtask

  task automatic test_single_write();
    do_write(6'd0, 8'hA5);
    do_write(6'd63, 8'h3C);
    do_read(6'd0, "single write read-back");
    do_read(6'd63, "single write read-back");
  endtask

  // Touches every word of every bank
  task automatic test_full_fill();
    data_t data;
    for (int a = 0; a < ram_bytes; a++) begin
      fresh_data(addr_t'(a), data);
      do_write(addr_t'(a), data);
    end
    for (int a = 0; a < ram_bytes; a++) begin
      do_read(addr_t'(a), "full fill");
    end
  endtask

  // Strobe held for four cycles, so only the first and third are taken
  task automatic test_back_to_back();
    addr_t addrs [4];
    data_t olds  [4];
    data_t data;
    addrs[0] = 6'd10;
    addrs[1] = 6'd27;
    addrs[2] = 6'd41;
    addrs[3] = 6'd54;
    for (int i = 0; i < 4; i++) begin
      olds[i] = ref_mem[addrs[i]];
    end
    for (int i = 0; i < 4; i++) begin
      fresh_data(addrs[i], data);
      drive_cycle(1'b1, addrs[i], data);
    end
    drive_cycle(1'b0, '0, '0);
    for (int i = 0; i < 4; i++) begin
      do_read(addrs[i], "back-to-back write");
    end
    // The rejected requests must leave the old bytes in place
    do_read(addrs[1], "blocked second request");
    check_data(data_t'(uo_out), olds[1], "blocked second request kept old value");
    do_read(addrs[3], "blocked fourth request");
    check_data(data_t'(uo_out), olds[3], "blocked fourth request kept old value");
  endtask

  task automatic test_bank_switching();
    logic [7:0] bits;
    for (int i = 0; i < 48; i++) begin
      take_bits(addr_bits, bits);
      do_read(addr_t'(bits[addr_bits-1:0]), "random read");
    end
  endtask

  // B is read while the write to A is still pending, then A is read
  task automatic test_read_during_write();
    addr_t a;
    addr_t b;
    data_t data;
    a = 6'd20;
    b = 6'd45;
    fresh_data(a, data);
    drive_cycle(1'b1, a, data);
    do_read(b, "read of other address during pending write");
    do_read(b, "read of other address during open gate");
    do_read(a, "read after pending write");
    check_data(data_t'(uo_out), data, "new data after pending write");
  endtask

  // Reset in the cycle after acceptance drops the write
  task automatic test_reset_cancel();
    addr_t a;
    data_t old;
    data_t data;
    a = 6'd33;
    old = ref_mem[a];
    fresh_data(a, data);
    drive_cycle(1'b1, a, data);
    apply_reset();
    do_read(a, "read after cancelled write");
    check_data(data_t'(uo_out), old, "cancelled write left old value");
  endtask

  initial begin
    rst_n      = 1'b0;
    ui_in      = 8'h00;
    uio_in     = 8'h00;
    pend_valid = 1'b0;
    pend_addr  = '0;
    pend_data  = '0;
    lfsr_state = 32'd74303;
    for (int i = 0; i < ram_bytes; i++) begin
      ref_mem[i]   = '0;
      ref_known[i] = 1'b0;
    end

    apply_reset();

    test_single_write();
    test_full_fill();
    test_back_to_back();
    test_bank_switching();
    test_read_during_write();
    test_reset_cancel();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
logic/latch_mem_pkg.sv
logic/write_sequencer.sv
logic/latch_array.sv
logic/bank_read_mux.sv
logic/latch_mem_top.sv
test/tb_latch_mem.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing -j 0 -f build.f --top-module tb_latch_mem \
  -o tb_latch_mem > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

# The simulation status is not used, the log decides
./obj_dir/tb_latch_mem > sim.log 2>&1

grep -q "TB PASSED" sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
